/* Makefile */
TOP = tb_pint_link

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module pint_link

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+.
pint_pkg.sv
pint_shift_if.sv
pint_baud_timer.sv
pint_link_fsm.sv
pint_tx_shifter.sv
pint_rx_shifter.sv
pint_link.sv
tb_pint_link.sv

/* pint_baud_timer.sv */
`include "pint_cfg.svh"

module pint_baud_timer (
	input logic clk,
	input logic reset,
	input logic run,
	input logic mute,
	output logic tick,
	output logic clk_level,
	output logic pint_clk
);

	// One spare bit so the counter could hold the divisor itself if it ever overran
	localparam int cnt_w = $clog2(`PINT_BAUD_DIV + 1);

	logic [cnt_w-1:0] cnt;
	logic link_clk;

	assign tick = run && (cnt == cnt_w'(`PINT_BAUD_DIV - 1));
	assign clk_level = link_clk;

	// The command bit goes out with the clock held low
	assign pint_clk = mute ? 1'b0 : link_clk;

	always_ff @(posedge clk) begin
		if (reset || !run) begin
			cnt <= '0;
			link_clk <= 1'b0;
		end else if (tick) begin
			cnt <= '0;
			link_clk <= ~link_clk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (reset)
		cnt < cnt_w'(`PINT_BAUD_DIV));

endmodule

/* pint_cfg.svh */
`ifndef PINT_CFG_SVH
`define PINT_CFG_SVH

// Number of clk cycles between baud ticks, so the link clock period is twice this
`define PINT_BAUD_DIV 4

// Largest number of data bytes carried in one frame
`define PINT_MAX_BYTES 5

`endif

/* pint_link.sv */
module pint_link (
	input logic clk,
	input logic reset,
	input logic tx_req,
	input logic tx_cmd_type,
	input pint_pkg::pint_data_t tx_data,
	input pint_pkg::pint_count_t tx_num_bytes,
	output logic busy,
	output logic rx_valid,
	output pint_pkg::pint_data_t rx_data,
	output pint_pkg::pint_count_t rx_num_bytes,
	output logic pint_wrreq,
	output logic pint_wrdata,
	output logic pint_clk,
	output logic pint_resetn,
	output logic pint_rdreq,
	input logic pint_rdrdy,
	input logic pint_rddata
);

	logic run;
	logic mute;
	logic tick;
	logic clk_level;

	pint_shift_if shift_bus ();

	// The device is held in reset for as long as the controller is
	assign pint_resetn = ~reset;

	pint_baud_timer u_timer (
		.clk(clk),
		.reset(reset),
		.run(run),
		.mute(mute),
		.tick(tick),
		.clk_level(clk_level),
		.pint_clk(pint_clk)
	);

	pint_link_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.pint_rdrdy(pint_rdrdy),
		.tick(tick),
		.clk_level(clk_level),
		.run(run),
		.mute(mute),
		.busy(busy),
		.pint_wrreq(pint_wrreq),
		.pint_rdreq(pint_rdreq),
		.rx_valid(rx_valid),
		.shift(shift_bus.fsm)
	);

	pint_tx_shifter u_tx (
		.clk(clk),
		.reset(reset),
		.tx_cmd_type(tx_cmd_type),
		.tx_data(tx_data),
		.tx_num_bytes(tx_num_bytes),
		.shift(shift_bus.tx),
		.pint_wrdata(pint_wrdata)
	);

	pint_rx_shifter u_rx (
		.clk(clk),
		.reset(reset),
		.pint_rddata(pint_rddata),
		.shift(shift_bus.rx),
		.rx_data(rx_data),
		.rx_num_bytes(rx_num_bytes)
	);

endmodule

/* pint_link_fsm.sv */
module pint_link_fsm (
	input logic clk,
	input logic reset,
	input logic tx_req,
	input logic pint_rdrdy,
	input logic tick,
	input logic clk_level,
	output logic run,
	output logic mute,
	output logic busy,
	output logic pint_wrreq,
	output logic pint_rdreq,
	output logic rx_valid,
	pint_shift_if.fsm shift
);

	import pint_pkg::*;

	pint_state_e state;
	logic rdy_meta;
	logic rdy_sync;
	logic rise_tick;
	logic fall_tick;

	// A tick with the clock low turns it high, and the other way round
	assign rise_tick = tick && !clk_level;
	assign fall_tick = tick && clk_level;

	assign busy = (state != st_idle);
	assign run = busy;
	assign pint_rdreq = (state == st_rx);

	// Ready comes straight from the device and is not related to clk
	always_ff @(posedge clk) begin
		if (reset) begin
			rdy_meta <= 1'b0;
			rdy_sync <= 1'b0;
		end else begin
			rdy_meta <= pint_rdrdy;
			rdy_sync <= rdy_meta;
		end
	end

	// Receive wins over transmit when both show up in idle
	always_comb begin
		shift.rx_clear = (state == st_idle) && rdy_sync;
		shift.tx_load = (state == st_idle) && !rdy_sync && tx_req;
		shift.rx_shift = rise_tick && (state == st_rx);
		shift.tx_shift = fall_tick &&
			((state == st_tx_cmd) || ((state == st_tx_data) && !shift.tx_last));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			mute <= 1'b0;
			pint_wrreq <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (rdy_sync) begin
						state <= st_rx;
					end else if (tx_req) begin
						state <= st_tx_cmd;
						mute <= 1'b1;
					end
				end
				st_tx_cmd: begin
					// The device takes the command bit on the rise of the request
					if (rise_tick) begin
						pint_wrreq <= 1'b1;
					end else if (fall_tick) begin
						mute <= 1'b0;
						state <= st_tx_data;
					end
				end
				st_tx_data: begin
					if (fall_tick && shift.tx_last) begin
						pint_wrreq <= 1'b0;
						state <= st_idle;
					end
				end
				st_rx: begin
					// The device drops ready once its last bit has been sampled
					if (fall_tick && !rdy_sync) begin
						rx_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	a_req_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(pint_wrreq && pint_rdreq));

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

/* pint_pkg.sv */
`include "pint_cfg.svh"

package pint_pkg;

	// Frame payload, right-justified, so a short frame sits in the low bytes
	typedef logic [8*`PINT_MAX_BYTES-1:0] pint_data_t;

	// Byte count of a frame
	typedef logic [2:0] pint_count_t;

	// Controller states
	// The command phase is kept apart from the data phase because the link clock
	// stays muted until the command bit has gone out
	typedef enum logic [1:0] {
		st_idle,
		st_tx_cmd,
		st_tx_data,
		st_rx
	} pint_state_e;

endpackage

/* pint_rx_shifter.sv */
`include "pint_cfg.svh"

module pint_rx_shifter (
	input logic clk,
	input logic reset,
	input logic pint_rddata,
	pint_shift_if.rx shift,
	output pint_pkg::pint_data_t rx_data,
	output pint_pkg::pint_count_t rx_num_bytes
);

	localparam int max_bits = 8 * `PINT_MAX_BYTES;

	logic [5:0] bit_cnt;
	logic take;

	// Bits past the payload width are dropped so the first ones stay in place
	assign take = shift.rx_shift && (bit_cnt < 6'(max_bits));

	always_ff @(posedge clk) begin
		if (reset || shift.rx_clear) begin
			bit_cnt <= '0;
		end else if (take) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// New bits enter at the LSB, which leaves the frame right-justified
	always_ff @(posedge clk) begin
		if (shift.rx_clear) begin
			rx_data <= '0;
		end else if (take) begin
			rx_data <= {rx_data[max_bits-2:0], pint_rddata};
		end
	end

	// A partial byte at the end is not counted
	assign rx_num_bytes = bit_cnt[5:3];

endmodule

/* pint_shift_if.sv */
interface pint_shift_if;

	// Transmit side strobes and the end-of-frame flag
	logic tx_load;
	logic tx_shift;
	logic tx_last;

	// Receive side strobes
	logic rx_shift;
	logic rx_clear;

	modport fsm (
		output tx_load,
		output tx_shift,
		output rx_shift,
		output rx_clear,
		input tx_last
	);

	modport tx (
		input tx_load,
		input tx_shift,
		output tx_last
	);

	modport rx (
		input rx_shift,
		input rx_clear
	);

endinterface

/* pint_trace.txt */
# T cmd nbytes data : transmit, data in hex right-justified
# R nbytes data : receive, B nbytes data : receive raced by tx_req, then tx_req while busy
T 1 1 a5
T 0 2 3c5a
T 1 3 f00fc3
R 1 96
T 0 4 8badf00d
T 1 5 c3a55a0ff0
R 2 a1b2
B 2 beef
R 3 00ff81
T 0 5 0000000001
R 5 123456789a
B 4 0f1e2d3c
R 4 80000001
T 1 1 00

/* pint_tx_shifter.sv */
`include "pint_cfg.svh"

module pint_tx_shifter (
	input logic clk,
	input logic reset,
	input logic tx_cmd_type,
	input pint_pkg::pint_data_t tx_data,
	input pint_pkg::pint_count_t tx_num_bytes,
	pint_shift_if.tx shift,
	output logic pint_wrdata
);

	import pint_pkg::*;

	localparam int data_w = 8 * `PINT_MAX_BYTES;

	logic [data_w:0] shreg;
	logic [5:0] bit_cnt;
	logic [5:0] pad;
	pint_count_t nbytes_q;
	pint_data_t aligned;

	// Move the low tx_num_bytes bytes up against the command bit so the
	// first data bit out is the MSB of the highest byte in use
	always_comb begin
		pad = 6'(data_w - 8 * int'(tx_num_bytes));
		aligned = tx_data << pad;
	end

	always_ff @(posedge clk) begin
		if (shift.tx_load) begin
			shreg <= {tx_cmd_type, aligned};
		end else if (shift.tx_shift) begin
			shreg <= {shreg[data_w-1:0], 1'b0};
		end
	end

	// Zero while the command bit is on the line, then the index of the data bit
	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			nbytes_q <= '0;
		end else if (shift.tx_load) begin
			bit_cnt <= '0;
			nbytes_q <= tx_num_bytes;
		end else if (shift.tx_shift) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	assign pint_wrdata = shreg[data_w];
	assign shift.tx_last = (bit_cnt == {nbytes_q, 3'b000});

	a_load_count: assert property (@(posedge clk) disable iff (reset)
		shift.tx_load |-> (tx_num_bytes inside {[1:`PINT_MAX_BYTES]}));

endmodule

/* tb_pint_link.sv */
`include "pint_cfg.svh"

module tb_pint_link;
	timeunit 1ns;
	timeprecision 1ps;

	import pint_pkg::*;

	localparam int timeout_cycles = 2000;

	logic clk = 1'b0;
	logic reset;
	logic tx_req;
	logic tx_cmd_type;
	pint_data_t tx_data;
	pint_count_t tx_num_bytes;
	logic busy;
	logic rx_valid;
	pint_data_t rx_data;
	pint_count_t rx_num_bytes;
	logic pint_wrreq;
	logic pint_wrdata;
	logic pint_clk;
	logic pint_resetn;
	logic pint_rdreq;
	logic pint_rdrdy;
	logic pint_rddata;
	logic [31:0] lfsr;

	pint_link uut (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Keeps the low nb bytes of a right-justified payload
	function automatic pint_data_t byte_mask(input pint_count_t nb);
		return {8*`PINT_MAX_BYTES{1'b1}} >> (8 * (`PINT_MAX_BYTES - int'(nb)));
	endfunction

	task automatic pick_gap(output int gap);
		gap = 0;
		for (int i = 0; i < 3; i++) begin
			gap = gap * 2 + int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// All sampling and driving happens just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic stop_with(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_data(input string name, input pint_data_t exp, input pint_data_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1, "data mismatch in %s", name);
		end
	endtask

	task automatic check_count(input string name, input pint_count_t exp, input pint_count_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			$display("Test failed");
			$fatal(1, "count mismatch in %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected %b actual %b", name, exp, act);
			$display("Test failed");
			$fatal(1, "bit mismatch in %s", name);
		end
	endtask

	task automatic run_transmit(input string name, input logic cmd, input pint_count_t nb,
			input pint_data_t data);
		logic prev_req;
		logic prev_clk;
		logic got_cmd;
		pint_data_t got;
		int nbits;
		int since_req;
		int n;
		tx_cmd_type = cmd;
		tx_data = data;
		tx_num_bytes = nb;
		tx_req = 1'b1;
		next_cycle();
		tx_req = 1'b0;
		check_bit({name, " busy after request"}, 1'b1, busy);
		prev_req = 1'b0;
		prev_clk = 1'b0;
		got_cmd = 1'bx;
		got = '0;
		nbits = 0;
		since_req = 0;
		n = 0;
		while (busy) begin
			// Device side takes the command bit on the rise of the request
			if (pint_wrreq && !prev_req)
				got_cmd = pint_wrdata;
			if (pint_wrreq && pint_clk && !prev_clk) begin
				got = {got[8*`PINT_MAX_BYTES-2:0], pint_wrdata};
				nbits++;
			end
			// Two baud periods of muted clock follow the rise of the request
			if (pint_wrreq && since_req < 2 * `PINT_BAUD_DIV)
				check_bit({name, " clock in command phase"}, 1'b0, pint_clk);
			if (pint_wrreq)
				since_req++;
			prev_req = pint_wrreq;
			prev_clk = pint_clk;
			next_cycle();
			n++;
			if (n > timeout_cycles)
				stop_with({name, ": busy did not fall at the end of the transmit"});
		end
		if (nbits > 8 * `PINT_MAX_BYTES)
			stop_with({name, ": more data bits were sent than one frame can hold"});
		check_bit({name, " write request at end"}, 1'b0, pint_wrreq);
		check_bit({name, " command bit"}, cmd, got_cmd);
		check_count({name, " bytes sent"}, nb, pint_count_t'(nbits / 8));
		check_bit({name, " partial byte"}, 1'b0, (nbits % 8) != 0);
		check_data({name, " data sent"}, data & byte_mask(nb), got);
	endtask

	task automatic run_receive(input string name, input pint_count_t nb, input pint_data_t data,
			input logic race);
		int nbits;
		int sent;
		int n;
		logic prev_clk;
		logic rise;
		nbits = 8 * int'(nb);
		sent = 0;
		n = 0;
		prev_clk = 1'b0;
		pint_rddata = data[nbits-1];
		pint_rdrdy = 1'b1;
		// Ready needs two cycles through the synchronizer, so this request meets it in idle
		if (race) begin
			next_cycle();
			next_cycle();
			tx_req = 1'b1;
			next_cycle();
		end
		while (!rx_valid) begin
			rise = pint_clk && !prev_clk;
			if (rise) begin
				// Every bit is clocked in under the read request
				check_bit({name, " read request while clocking"}, 1'b1, pint_rdreq);
				sent++;
				if (sent == nbits)
					pint_rdrdy = 1'b0;
			end
			if (!pint_clk && prev_clk && sent < nbits)
				pint_rddata = data[nbits-1-sent];
			// A second request lands in the middle of the receive
			tx_req = race && rise && (sent == 2);
			check_bit({name, " write request during receive"}, 1'b0, pint_wrreq);
			prev_clk = pint_clk;
			next_cycle();
			n++;
			if (n > timeout_cycles)
				stop_with({name, ": rx_valid did not arrive at the end of the receive"});
		end
		check_data({name, " rx_data"}, data & byte_mask(nb), rx_data);
		check_count({name, " rx_num_bytes"}, nb, rx_num_bytes);
		check_bit({name, " read request at end"}, 1'b0, pint_rdreq);
		next_cycle();
		check_bit({name, " rx_valid pulse"}, 1'b0, rx_valid);
		for (int i = 0; i < 4 * `PINT_BAUD_DIV; i++) begin
			check_bit({name, " busy after receive"}, 1'b0, busy);
			check_bit({name, " write request after receive"}, 1'b0, pint_wrreq);
			next_cycle();
		end
	endtask

	initial begin
		int fd;
		int cmd;
		int nb;
		int gap;
		int lineno;
		string line;
		string name;
		pint_data_t data;
		reset = 1'b1;
		tx_req = 1'b0;
		tx_cmd_type = 1'b0;
		tx_data = '0;
		tx_num_bytes = 3'd1;
		pint_rdrdy = 1'b0;
		pint_rddata = 1'b0;
		lfsr = 32'h9c8b5431;
		repeat (2) @(posedge clk);
		#5;
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset pint_wrreq", 1'b0, pint_wrreq);
		check_bit("reset pint_rdreq", 1'b0, pint_rdreq);
		check_bit("reset rx_valid", 1'b0, rx_valid);
		check_bit("reset pint_clk", 1'b0, pint_clk);
		check_bit("reset pint_resetn", 1'b0, pint_resetn);
		reset = 1'b0;
		next_cycle();
		check_bit("release pint_resetn", 1'b1, pint_resetn);
		fd = $fopen("pint_trace.txt", "r");
		if (fd == 0)
			stop_with("the trace file pint_trace.txt could not be opened");
		lineno = 0;
		while ($fgets(line, fd) != 0) begin
			lineno++;
			name = $sformatf("line %0d", lineno);
			if (line.len() > 1 && line.getc(0) != "#") begin
				pick_gap(gap);
				repeat (gap) next_cycle();
				case (line.getc(0))
					"T": begin
						void'($sscanf(line, "T %d %d %h", cmd, nb, data));
						run_transmit({name, " transmit"}, cmd[0], pint_count_t'(nb), data);
					end
					"R": begin
						void'($sscanf(line, "R %d %h", nb, data));
						run_receive({name, " receive"}, pint_count_t'(nb), data, 1'b0);
					end
					"B": begin
						void'($sscanf(line, "B %d %h", nb, data));
						run_receive({name, " raced receive"}, pint_count_t'(nb), data, 1'b1);
					end
					default: stop_with({name, ": the trace holds an unknown operation"});
				endcase
			end
		end
		$fclose(fd);
		$display("Test passed");
		$finish;
	end

endmodule
